/* source/ooo_pkg.sv */
package ooo_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // one data word
    localparam int XLEN      = 32;
    // architectural registers
    localparam int REG_NUM   = 32;
    localparam int REG_IDX_W = 5;
    // reorder buffer, one tag per entry
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = 3;
    // reservation station entries
    localparam int RS_DEPTH  = 4;
    localparam int RS_IDX_W  = 2;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    // rob index, doubles as the rename tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    //////////////////////////////////////////////////
    // alu functions
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    //////////////////////////////////////////////////
    // rv32 encodings
    //////////////////////////////////////////////////

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, plain and sub/sra variant
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import ooo_pkg::*; (
    input  xlen_t     inst,
    input  logic      inst_valid,
    output alu_func_e alu_func,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output logic      has_dest,
    output xlen_t     imm,
    output logic      illegal
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_nonzero;
    alu_func_e  base_func;

    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign rd_nonzero = (inst[11:7] != '0);

    // funct3 alone picks the plain function
    always_comb begin
        case (funct3)
            F3_ADD_SUB: base_func = ALU_ADD;
            F3_SLL:     base_func = ALU_SLL;
            F3_SLT:     base_func = ALU_SLT;
            F3_SLTU:    base_func = ALU_SLTU;
            F3_XOR:     base_func = ALU_XOR;
            F3_SRL_SRA: base_func = ALU_SRL;
            F3_OR:      base_func = ALU_OR;
            default:    base_func = ALU_AND;
        endcase
    end

    always_comb begin
        // nop defaults
        alu_func = ALU_ADD;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        has_dest = 1'b0;
        imm      = '0;
        illegal  = 1'b0;

        if (inst_valid) begin
            case (opcode)
                OPCODE_LUI: begin
                    // zero + u immediate
                    has_dest = rd_nonzero;
                    imm      = {inst[31:12], 12'b0};
                end
                OPCODE_OP_IMM: begin
                    uses_rs1 = 1'b1;
                    has_dest = rd_nonzero;
                    imm      = {{20{inst[31]}}, inst[31:20]};
                    alu_func = base_func;
                    // shamt forms keep funct7 in the upper imm bits
                    if (funct3 == F3_SLL) begin
                        illegal = (funct7 != FUNCT7_BASE);
                    end else if (funct3 == F3_SRL_SRA) begin
                        if (funct7 == FUNCT7_ALT) begin
                            alu_func = ALU_SRA;
                        end else begin
                            illegal = (funct7 != FUNCT7_BASE);
                        end
                    end
                end
                OPCODE_OP: begin
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                    has_dest = rd_nonzero;
                    if (funct7 == FUNCT7_BASE) begin
                        alu_func = base_func;
                    end else if (funct7 == FUNCT7_ALT && funct3 == F3_ADD_SUB) begin
                        alu_func = ALU_SUB;
                    end else if (funct7 == FUNCT7_ALT && funct3 == F3_SRL_SRA) begin
                        alu_func = ALU_SRA;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase

            // illegal reads nothing, writes nothing
            if (illegal) begin
                uses_rs1 = 1'b0;
                uses_rs2 = 1'b0;
                has_dest = 1'b0;
            end
        end
    end

endmodule

/* source/map_table.sv */
`timescale 1ns/10ps

module map_table import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     rename_en,
    input  reg_idx_t rename_reg,
    input  rob_tag_t rename_tag,
    input  logic     retire_en,
    input  reg_idx_t retire_reg,
    input  rob_tag_t retire_tag,
    output logic     rs1_busy,
    output rob_tag_t rs1_tag,
    output logic     rs2_busy,
    output rob_tag_t rs2_tag
);
    logic [REG_NUM-1:0] busy_q;
    rob_tag_t           tag_q [REG_NUM];
    logic               retire_match;

    // combinational lookup
    assign rs1_busy = busy_q[rs1];
    assign rs1_tag  = tag_q[rs1];
    assign rs2_busy = busy_q[rs2];
    assign rs2_tag  = tag_q[rs2];

    // only the newest producer may clear the mapping
    assign retire_match = retire_en && busy_q[retire_reg] && (tag_q[retire_reg] == retire_tag);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            if (retire_match) begin
                busy_q[retire_reg] <= 1'b0;
            end
            // rename after retire, so rename wins
            if (rename_en) begin
                busy_q[rename_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename_en) begin
            tag_q[rename_reg] <= rename_tag;
        end
    end

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     alloc_en,
    input  reg_idx_t alloc_dest,
    input  logic     alloc_illegal,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  xlen_t    cdb_value,
    input  rob_tag_t read_tag1,
    input  rob_tag_t read_tag2,
    output rob_tag_t alloc_tag,
    output logic     full,
    output logic     read_done1,
    output xlen_t    read_value1,
    output logic     read_done2,
    output xlen_t    read_value2,
    output logic     retire_valid,
    output reg_idx_t retire_dest,
    output xlen_t    retire_value,
    output logic     retire_illegal,
    output rob_tag_t retire_tag
);
    rob_tag_t             head, tail;
    logic [ROB_TAG_W:0]   count;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] illegal_q;
    reg_idx_t             dest_q [ROB_DEPTH];
    xlen_t                value_q [ROB_DEPTH];
    logic                 head_cdb, pop;

    //////////////////////////////////////////////////
    // status and operand reads
    //////////////////////////////////////////////////

    assign alloc_tag = tail;
    assign full      = (count == ROB_DEPTH);

    // done bits survive retire, values stay readable one more cycle
    assign read_done1  = done_q[read_tag1];
    assign read_value1 = value_q[read_tag1];
    assign read_done2  = done_q[read_tag2];
    assign read_value2 = value_q[read_tag2];

    // head result arriving right now
    assign head_cdb = cdb_valid && (cdb_tag == head);
    assign pop      = (count != '0) && (done_q[head] || head_cdb);

    //////////////////////////////////////////////////
    // pointers and done bits
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            retire_valid <= 1'b0;
        end else begin
            if (cdb_valid) begin
                done_q[cdb_tag] <= 1'b1;
            end
            // illegal entry has nothing to wait for
            if (alloc_en) begin
                done_q[tail] <= alloc_illegal;
                tail         <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count        <= count + (ROB_TAG_W+1)'(alloc_en) - (ROB_TAG_W+1)'(pop);
            retire_valid <= pop;
        end
    end

    //////////////////////////////////////////////////
    // entry payload and retire outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc_en) begin
            dest_q[tail]    <= alloc_dest;
            illegal_q[tail] <= alloc_illegal;
            value_q[tail]   <= '0;
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;
        end
        if (pop) begin
            retire_dest    <= dest_q[head];
            retire_value   <= head_cdb ? cdb_value : value_q[head];
            retire_illegal <= illegal_q[head];
            retire_tag     <= head;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps

module reg_file import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t read_idx1,
    input  reg_idx_t read_idx2,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  xlen_t    write_data,
    output xlen_t    read_data1,
    output xlen_t    read_data2
);
    // x1..x31, x0 is not stored
    xlen_t regs [1:REG_NUM-1];

    assign read_data1 = (read_idx1 == '0) ? '0 : regs[read_idx1];
    assign read_data2 = (read_idx2 == '0) ? '0 : regs[read_idx2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

endmodule

/* source/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station import ooo_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      load_en,
    input  rob_tag_t  load_tag,
    input  alu_func_e load_alu_func,
    input  xlen_t     opa_value,
    input  logic      opa_ready,
    input  rob_tag_t  opa_tag,
    input  xlen_t     opb_value,
    input  logic      opb_ready,
    input  rob_tag_t  opb_tag,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  xlen_t     cdb_value,
    input  logic      issue_ready,
    output logic      has_free,
    output logic      issue_valid,
    output rob_tag_t  issue_tag,
    output alu_func_e issue_alu_func,
    output xlen_t     issue_opa,
    output xlen_t     issue_opb
);
    logic [RS_DEPTH-1:0] valid_q, opa_rdy_q, opb_rdy_q;
    logic [RS_DEPTH-1:0] wake_a, wake_b;
    rob_tag_t            tag_q [RS_DEPTH];
    alu_func_e           func_q [RS_DEPTH];
    xlen_t               opa_q [RS_DEPTH];
    xlen_t               opb_q [RS_DEPTH];
    rob_tag_t            opa_tag_q [RS_DEPTH];
    rob_tag_t            opb_tag_q [RS_DEPTH];
    logic [RS_IDX_W-1:0] free_idx, ready_idx, issue_idx, hold_idx_q;
    logic                ready_found, hold_q, issue_fire;

    //////////////////////////////////////////////////
    // select and wakeup
    //////////////////////////////////////////////////

    // scan downward so the lowest index wins
    always_comb begin
        free_idx    = '0;
        ready_idx   = '0;
        ready_found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = RS_IDX_W'(i);
            end
            if (valid_q[i] && opa_rdy_q[i] && opb_rdy_q[i]) begin
                ready_idx   = RS_IDX_W'(i);
                ready_found = 1'b1;
            end
        end
    end

    // cdb match on a waiting operand
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake_a[i] = valid_q[i] && !opa_rdy_q[i] && cdb_valid && (cdb_tag == opa_tag_q[i]);
            wake_b[i] = valid_q[i] && !opb_rdy_q[i] && cdb_valid && (cdb_tag == opb_tag_q[i]);
        end
    end

    assign has_free = ~&valid_q;

    // a stalled offer stays on the same entry
    assign issue_idx   = hold_q ? hold_idx_q : ready_idx;
    assign issue_valid = hold_q || ready_found;
    assign issue_fire  = issue_valid && issue_ready;

    assign issue_tag      = tag_q[issue_idx];
    assign issue_alu_func = func_q[issue_idx];
    assign issue_opa      = opa_q[issue_idx];
    assign issue_opb      = opb_q[issue_idx];

    //////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            opa_rdy_q  <= '0;
            opb_rdy_q  <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            opa_rdy_q <= opa_rdy_q | wake_a;
            opb_rdy_q <= opb_rdy_q | wake_b;
            // freed on acceptance
            if (issue_fire) begin
                valid_q[issue_idx] <= 1'b0;
            end
            if (load_en) begin
                valid_q[free_idx]   <= 1'b1;
                opa_rdy_q[free_idx] <= opa_ready;
                opb_rdy_q[free_idx] <= opb_ready;
            end
            hold_q     <= issue_valid && !issue_ready;
            hold_idx_q <= issue_idx;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake_a[i]) begin
                opa_q[i] <= cdb_value;
            end
            if (wake_b[i]) begin
                opb_q[i] <= cdb_value;
            end
        end
        if (load_en) begin
            tag_q[free_idx]     <= load_tag;
            func_q[free_idx]    <= load_alu_func;
            opa_q[free_idx]     <= opa_value;
            opb_q[free_idx]     <= opb_value;
            opa_tag_q[free_idx] <= opa_tag;
            opb_tag_q[free_idx] <= opb_tag;
        end
    end

endmodule

/* source/dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage import ooo_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  xlen_t     inst,
    output logic      inst_ready,
    output logic      issue_valid,
    input  logic      issue_ready,
    output rob_tag_t  issue_tag,
    output alu_func_e issue_alu_func,
    output xlen_t     issue_opa,
    output xlen_t     issue_opb,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  xlen_t     cdb_value,
    output logic      retire_valid,
    output reg_idx_t  retire_dest,
    output xlen_t     retire_value,
    output logic      retire_illegal
);
    reg_idx_t  rs1, rs2, rd, alloc_dest;
    alu_func_e dec_alu_func;
    logic      dec_uses_rs1, dec_uses_rs2, dec_has_dest, dec_illegal;
    xlen_t     dec_imm;
    logic      rs1_busy, rs2_busy;
    rob_tag_t  rs1_tag, rs2_tag, alloc_tag, rob_retire_tag;
    logic      rob_full, rob_done1, rob_done2, rs_has_free;
    xlen_t     rob_value1, rob_value2, rf_data1, rf_data2;
    logic      dispatch_en, retire_write;
    logic      opa_ready, opb_ready;
    xlen_t     opa_value, opb_value;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // state only, never looks at inst_valid
    assign inst_ready  = !rob_full && rs_has_free;
    assign dispatch_en = inst_valid && inst_ready;
    assign alloc_dest  = dec_has_dest ? rd : '0;

    // illegal entries never reach the register file
    assign retire_write = retire_valid && !retire_illegal;

    //////////////////////////////////////////////////
    // operand sourcing
    //////////////////////////////////////////////////

    // {ready, value} for one renamed source
    function automatic logic [XLEN:0] source_operand(
        input logic     busy,
        input rob_tag_t tag,
        input logic     rob_done,
        input xlen_t    rob_value,
        input xlen_t    rf_value,
        input logic     bus_valid,
        input rob_tag_t bus_tag,
        input xlen_t    bus_value
    );
        if (!busy) begin
            return {1'b1, rf_value};
        end else if (rob_done) begin
            return {1'b1, rob_value};
        end else if (bus_valid && bus_tag == tag) begin
            // result broadcast in the dispatch cycle
            return {1'b1, bus_value};
        end
        return {1'b0, xlen_t'(0)};
    endfunction

    always_comb begin
        // lui takes zero for operand a
        {opa_ready, opa_value} = {1'b1, xlen_t'(0)};
        if (dec_uses_rs1) begin
            {opa_ready, opa_value} = source_operand(rs1_busy, rs1_tag, rob_done1,
                rob_value1, rf_data1, cdb_valid, cdb_tag, cdb_value);
        end
        // immediate forms take imm for operand b
        {opb_ready, opb_value} = {1'b1, dec_imm};
        if (dec_uses_rs2) begin
            {opb_ready, opb_value} = source_operand(rs2_busy, rs2_tag, rob_done2,
                rob_value2, rf_data2, cdb_valid, cdb_tag, cdb_value);
        end
    end

    //////////////////////////////////////////////////
    // submodules
    //////////////////////////////////////////////////

    inst_decoder u_decoder (
        .inst(inst), .inst_valid(inst_valid), .alu_func(dec_alu_func),
        .uses_rs1(dec_uses_rs1), .uses_rs2(dec_uses_rs2), .has_dest(dec_has_dest),
        .imm(dec_imm), .illegal(dec_illegal)
    );

    map_table u_map_table (
        .clock(clock), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
        .rename_en(dispatch_en && dec_has_dest), .rename_reg(rd), .rename_tag(alloc_tag),
        .retire_en(retire_write), .retire_reg(retire_dest), .retire_tag(rob_retire_tag),
        .rs1_busy(rs1_busy), .rs1_tag(rs1_tag), .rs2_busy(rs2_busy), .rs2_tag(rs2_tag)
    );

    reorder_buffer u_rob (
        .clock(clock), .rst_n(rst_n), .alloc_en(dispatch_en), .alloc_dest(alloc_dest),
        .alloc_illegal(dec_illegal), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value), .read_tag1(rs1_tag), .read_tag2(rs2_tag),
        .alloc_tag(alloc_tag), .full(rob_full), .read_done1(rob_done1),
        .read_value1(rob_value1), .read_done2(rob_done2), .read_value2(rob_value2),
        .retire_valid(retire_valid), .retire_dest(retire_dest), .retire_value(retire_value),
        .retire_illegal(retire_illegal), .retire_tag(rob_retire_tag)
    );

    reg_file u_reg_file (
        .clock(clock), .rst_n(rst_n), .read_idx1(rs1), .read_idx2(rs2),
        .write_en(retire_write), .write_idx(retire_dest), .write_data(retire_value),
        .read_data1(rf_data1), .read_data2(rf_data2)
    );

    // illegal instructions skip the station
    reservation_station u_rs (
        .clock(clock), .rst_n(rst_n), .load_en(dispatch_en && !dec_illegal),
        .load_tag(alloc_tag), .load_alu_func(dec_alu_func),
        .opa_value(opa_value), .opa_ready(opa_ready), .opa_tag(rs1_tag),
        .opb_value(opb_value), .opb_ready(opb_ready), .opb_tag(rs2_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .issue_ready(issue_ready), .has_free(rs_has_free), .issue_valid(issue_valid),
        .issue_tag(issue_tag), .issue_alu_func(issue_alu_func),
        .issue_opa(issue_opa), .issue_opb(issue_opb)
    );

endmodule

/* include/dispatch_stage_tb_table.svh */
// one row per instruction, in program order
// name, inst word, retire dest, retire value, retire illegal
task automatic fill_table();
    // dependent chain from reset state
    add_entry("lui x1, 0x12345",     32'h123450b7, 5'd1,  32'h12345000, 1'b0);
    add_entry("addi x2, x1, 0x678",  32'h67808113, 5'd2,  32'h12345678, 1'b0);
    add_entry("addi x3, x0, -1",     32'hfff00193, 5'd3,  32'hffffffff, 1'b0);
    add_entry("add x4, x2, x3",      32'h00310233, 5'd4,  32'h12345677, 1'b0);
    add_entry("sub x5, x4, x1",      32'h401202b3, 5'd5,  32'h00000677, 1'b0);
    add_entry("xor x6, x2, x3",      32'h00314333, 5'd6,  32'hedcba987, 1'b0);
    add_entry("slli x7, x5, 4",      32'h00429393, 5'd7,  32'h00006770, 1'b0);
    add_entry("srai x8, x6, 4",      32'h40435413, 5'd8,  32'hfedcba98, 1'b0);
    add_entry("srli x9, x6, 4",      32'h00435493, 5'd9,  32'h0edcba98, 1'b0);
    add_entry("slt x10, x8, x9",     32'h00942533, 5'd10, 32'h00000001, 1'b0);
    add_entry("sltu x11, x8, x9",    32'h009435b3, 5'd11, 32'h00000000, 1'b0);
    // mul is not supported, x10 keeps its value
    add_entry("mul x10, x2, x3",     32'h02310533, 5'd0,  32'h00000000, 1'b1);
    add_entry("ori x12, x10, 0x100", 32'h10056613, 5'd12, 32'h00000101, 1'b0);
    add_entry("add x0, x2, x3",      32'h00310033, 5'd0,  32'h12345677, 1'b0);
    add_entry("add x13, x0, x1",     32'h001006b3, 5'd13, 32'h12345000, 1'b0);
    // issue stall begins at this row
    add_entry("and x14, x9, x2",     32'h0024f733, 5'd14, 32'h02141218, 1'b0);
    add_entry("or x15, x7, x5",      32'h0053e7b3, 5'd15, 32'h00006777, 1'b0);
    add_entry("sll x16, x1, x10",    32'h00a09833, 5'd16, 32'h2468a000, 1'b0);
    add_entry("sra x17, x8, x12",    32'h40c458b3, 5'd17, 32'hff6e5d4c, 1'b0);
    add_entry("srl x18, x8, x12",    32'h00c45933, 5'd18, 32'h7f6e5d4c, 1'b0);
    add_entry("xori x19, x18, -1",   32'hfff94993, 5'd19, 32'h8091a2b3, 1'b0);
    add_entry("slti x20, x19, -5",   32'hffb9aa13, 5'd20, 32'h00000001, 1'b0);
    add_entry("andi x22, x2, 0xff",  32'h0ff17b13, 5'd22, 32'h00000078, 1'b0);
    add_entry("add x23, x22, x20",   32'h014b0bb3, 5'd23, 32'h00000079, 1'b0);
endtask

/* sim/dispatch_stage_tb.sv */
`timescale 1ns/10ps

module dispatch_stage_tb import ooo_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    // table index where the issue stall starts
    localparam int STALL_AT       = 15;

    logic      clock;
    logic      rst_n;
    logic      inst_valid;
    xlen_t     inst;
    logic      inst_ready;
    logic      issue_valid;
    logic      issue_ready;
    rob_tag_t  issue_tag;
    alu_func_e issue_alu_func;
    xlen_t     issue_opa;
    xlen_t     issue_opb;
    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    xlen_t     cdb_value;
    logic      retire_valid;
    reg_idx_t  retire_dest;
    xlen_t     retire_value;
    logic      retire_illegal;

    // one row per instruction
    string    tbl_name[$];
    xlen_t    tbl_inst[$];
    reg_idx_t tbl_dest[$];
    xlen_t    tbl_value[$];
    logic     tbl_illegal[$];

    // results in flight inside the functional unit
    rob_tag_t pend_tag[$];
    xlen_t    pend_value[$];
    int       pend_delay[$];

    integer   seed = 40979;
    int       errors;
    int       checks;
    int       retire_count;
    logic     stall;
    logic     saw_full;
    logic     hold_seen;
    rob_tag_t held_tag;
    alu_func_e held_func;
    xlen_t    held_opa;
    xlen_t    held_opb;

    dispatch_stage u_dut (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    //////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input xlen_t word, input reg_idx_t dest,
                             input xlen_t value, input logic illegal);
        tbl_name.push_back(name);
        tbl_inst.push_back(word);
        tbl_dest.push_back(dest);
        tbl_value.push_back(value);
        tbl_illegal.push_back(illegal);
    endtask

    `include "dispatch_stage_tb_table.svh"

    // in-order compare against the next table row
    task automatic check_retire();
        int idx;
        idx = retire_count;
        if (idx >= tbl_inst.size()) begin
            errors++;
            $display("extra retire past the end of the table, dest %0d", retire_dest);
        end else begin
            check_value($sformatf("%s dest", tbl_name[idx]), 32'(tbl_dest[idx]),
                32'(retire_dest));
            check_value($sformatf("%s value", tbl_name[idx]), tbl_value[idx], retire_value);
            check_value($sformatf("%s illegal", tbl_name[idx]), 32'(tbl_illegal[idx]),
                32'(retire_illegal));
        end
        retire_count++;
    endtask

    always @(negedge clock) begin
        if (rst_n && retire_valid) begin
            check_retire();
        end
    end

    //////////////////////////////////////////////////
    // functional unit model
    //////////////////////////////////////////////////

    function automatic xlen_t alu_result(input alu_func_e func, input xlen_t a, input xlen_t b);
        case (func)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            // rv32 shifts use the low five bits only
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    // just before the edge, issue outputs are settled
    task automatic sample_issue();
        if (hold_seen) begin
            check_value("stalled offer valid", 32'd1, 32'(issue_valid));
            check_value("stalled offer tag", 32'(held_tag), 32'(issue_tag));
            check_value("stalled offer func", 32'(held_func), 32'(issue_alu_func));
            check_value("stalled offer opa", held_opa, issue_opa);
            check_value("stalled offer opb", held_opb, issue_opb);
        end
        hold_seen = issue_valid && !issue_ready;
        held_tag  = issue_tag;
        held_func = issue_alu_func;
        held_opa  = issue_opa;
        held_opb  = issue_opb;
        if (issue_valid && issue_ready) begin
            pend_tag.push_back(issue_tag);
            pend_value.push_back(alu_result(issue_alu_func, issue_opa, issue_opb));
            pend_delay.push_back({$random(seed)} % 5);
        end
    endtask

    // first expired result goes out, so later issues can overtake
    task automatic drive_fu();
        int pick;
        int coin;
        pick      = -1;
        coin      = {$random(seed)} % 4;
        cdb_valid = 1'b0;
        for (int i = 0; i < pend_tag.size(); i++) begin
            if (pick < 0 && pend_delay[i] == 0) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            cdb_valid = 1'b1;
            cdb_tag   = pend_tag[pick];
            cdb_value = pend_value[pick];
            pend_tag.delete(pick);
            pend_value.delete(pick);
            pend_delay.delete(pick);
        end
        // the rest age by one cycle
        for (int i = 0; i < pend_delay.size(); i++) begin
            if (pend_delay[i] > 0) begin
                pend_delay[i]--;
            end
        end
        issue_ready = !stall && (pend_tag.size() < ROB_DEPTH) && (coin != 0);
    endtask

    initial begin
        issue_ready = 1'b0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        cdb_value   = '0;
        hold_seen   = 1'b0;
        held_tag    = '0;
        held_func   = ALU_ADD;
        held_opa    = '0;
        held_opb    = '0;
        forever begin
            @(negedge clock);
            sample_issue();
            @(posedge clock);
            #1;
            drive_fu();
        end
    end

    //////////////////////////////////////////////////
    // dispatch and main sequence
    //////////////////////////////////////////////////

    task automatic dispatch_one(input int idx);
        int waited;
        int full_cycles;
        waited      = 0;
        full_cycles = 0;
        @(posedge clock);
        #1;
        inst_valid = 1'b1;
        inst       = tbl_inst[idx];
        @(negedge clock);
        while (!inst_ready && waited < TIMEOUT_CYCLES) begin
            // release the stall once the DUT has pushed back a while
            if (stall) begin
                full_cycles++;
                if (full_cycles == 4) begin
                    stall    = 1'b0;
                    saw_full = 1'b1;
                end
            end
            waited++;
            @(negedge clock);
        end
        if (!inst_ready) begin
            errors++;
            $display("timeout, %s was never accepted", tbl_name[idx]);
        end
    endtask

    task automatic wait_retired();
        int waited;
        waited = 0;
        while (retire_count < tbl_inst.size() && waited < TIMEOUT_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        if (retire_count < tbl_inst.size()) begin
            errors++;
            $display("timeout, only %0d of %0d instructions retired", retire_count,
                tbl_inst.size());
        end
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        retire_count = 0;
        stall        = 1'b0;
        saw_full     = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        fill_table();
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // idle state right after reset
        @(negedge clock);
        check_value("reset inst_ready", 32'd1, 32'(inst_ready));
        check_value("reset issue_valid", 32'd0, 32'(issue_valid));
        check_value("reset retire_valid", 32'd0, 32'(retire_valid));

        for (int i = 0; i < tbl_inst.size(); i++) begin
            if (i == STALL_AT) begin
                stall = 1'b1;
            end
            dispatch_one(i);
        end
        @(posedge clock);
        #1;
        inst_valid = 1'b0;

        // back-pressure must have reached inst_ready
        check_value("inst_ready fell under stall", 32'd1, 32'(saw_full));
        stall = 1'b0;

        wait_retired();
        // quiet period to catch duplicate retires
        repeat (8) @(posedge clock);

        $display("done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
source/ooo_pkg.sv
source/inst_decoder.sv
source/map_table.sv
source/reorder_buffer.sv
source/reg_file.sv
source/reservation_station.sv
source/dispatch_stage.sv
sim/dispatch_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dispatch stage testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module dispatch_stage_tb \
    -f flist.f \
    -o dispatch_stage_tb

./obj_dir/dispatch_stage_tb > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0
